//--- hdl/graph_ctrl_pkg.sv
package graph_ctrl_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////

	localparam int NUM_CU           = 4;
	localparam int CU_ID_BITS       = 2;
	localparam int VERTEX_ID_BITS   = 16;
	localparam int EDGE_COUNT_BITS  = 8;
	localparam int ADDR_BITS        = 32;
	localparam int DATA_BITS        = 32;
	localparam int COUNT_BITS       = 16;
	localparam int JOB_BUFFER_DEPTH = 8;
	localparam int CMD_BUFFER_DEPTH = 4;

	//////////////////////////////////////////////////
	// bus types
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                       valid;
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [EDGE_COUNT_BITS-1:0] edge_count;
		logic [ADDR_BITS-1:0]       edge_base;
	} vertex_job_t;

	typedef struct packed {
		logic                  valid;
		logic [CU_ID_BITS-1:0] cu_id;
		logic [ADDR_BITS-1:0]  addr;
	} read_cmd_t;

	typedef struct packed {
		logic                  valid;
		logic [CU_ID_BITS-1:0] cu_id;
		logic [DATA_BITS-1:0]  data;
	} read_data_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status_t;

	typedef enum logic [1:0] {
		CU_IDLE  = 2'd0,
		CU_ISSUE = 2'd1,
		CU_WAIT  = 2'd2
	} cu_state_e;

	// first requester after last, or last when nobody requests
	function automatic logic [CU_ID_BITS-1:0] rr_next(
		input logic [NUM_CU-1:0]     req,
		input logic [CU_ID_BITS-1:0] last
	);
		logic [CU_ID_BITS-1:0] pick;
		logic [CU_ID_BITS-1:0] idx;
		logic                  found;
		pick  = last;
		found = 1'b0;
		for (int k = 1; k <= NUM_CU; k++) begin
			idx = CU_ID_BITS'((int'(last) + k) % NUM_CU);
			if (!found && req[idx]) begin
				pick  = idx;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic                          clock,
	input  logic                          rstn,
	input  logic                          push,
	input  logic [WIDTH-1:0]              data_in,
	input  logic                          pop,
	output logic [WIDTH-1:0]              data_out,
	output graph_ctrl_pkg::buffer_status_t status
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	// head entry visible without a pop
	assign data_out = mem[rd_ptr];

	assign status.full   = (int'(count) == DEPTH);
	assign status.alfull = (int'(count) >= DEPTH - 1);
	assign status.empty  = (count == '0);
	assign status.valid  = (count != '0);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hdl/job_dispatch.sv
`timescale 1ns/100ps

module job_dispatch import graph_ctrl_pkg::*; (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled,
	input  vertex_job_t          job_in,
	input  buffer_status_t       job_status,
	output logic                 job_pop,
	input  logic [NUM_CU-1:0]    cu_request,
	output vertex_job_t          cu_job [NUM_CU]
);

	logic [CU_ID_BITS-1:0] last;
	logic [CU_ID_BITS-1:0] pick;
	logic [NUM_CU-1:0]     assigned;
	logic [NUM_CU-1:0]     eligible;
	vertex_job_t           job_q;

	// a unit given a job last cycle still shows its request, skip it
	assign eligible = cu_request & ~assigned;
	assign pick     = rr_next(eligible, last);
	assign job_pop  = enabled && !job_status.empty && (|eligible);

	//////////////////////////////////////////////////
	// assignment registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last     <= '0;
			assigned <= '0;
		end else begin
			if (job_pop) begin
				last <= pick;
			end
			for (int i = 0; i < NUM_CU; i++) begin
				assigned[i] <= job_pop && (pick == CU_ID_BITS'(i));
			end
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop) begin
			job_q <= job_in;
		end
	end

	// one-cycle valid pulse at the chosen unit only
	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			cu_job[i]       = job_q;
			cu_job[i].valid = assigned[i];
		end
	end

endmodule

//--- hdl/vertex_cu.sv
`timescale 1ns/100ps

module vertex_cu import graph_ctrl_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [CU_ID_BITS-1:0] cu_id,
	input  vertex_job_t           job,
	output logic                  job_request,
	input  logic                  cmd_buffer_alfull,
	output read_cmd_t             cmd,
	input  read_data_t            data_in,
	output logic [COUNT_BITS-1:0] vertex_count,
	output logic [COUNT_BITS-1:0] edge_count
);

	cu_state_e                  state;
	logic [EDGE_COUNT_BITS-1:0] edges;
	logic [EDGE_COUNT_BITS-1:0] issue_cnt;
	logic [EDGE_COUNT_BITS-1:0] ret_cnt;
	logic [EDGE_COUNT_BITS-1:0] ret_next;
	logic [ADDR_BITS-1:0]       next_addr;
	logic                       issue;

	assign job_request = (state == CU_IDLE);
	// the extra free slot covers the command still in the output register
	assign issue       = (state == CU_ISSUE) && !cmd_buffer_alfull;
	assign ret_next    = ret_cnt + EDGE_COUNT_BITS'(data_in.valid);

	//////////////////////////////////////////////////
	// state machine and totals
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= CU_IDLE;
			issue_cnt    <= '0;
			ret_cnt      <= '0;
			vertex_count <= '0;
			edge_count   <= '0;
			cmd          <= '0;
		end else begin
			cmd.valid <= issue;
			if (issue) begin
				cmd.cu_id <= cu_id;
				cmd.addr  <= next_addr;
			end
			if (data_in.valid) begin
				edge_count <= edge_count + 1'b1;
			end
			case (state)
				CU_IDLE: begin
					if (job.valid) begin
						issue_cnt <= '0;
						ret_cnt   <= '0;
						if (job.edge_count == '0) begin
							vertex_count <= vertex_count + 1'b1;
						end else begin
							state <= CU_ISSUE;
						end
					end
				end
				CU_ISSUE: begin
					// data may come back before the last command goes out
					ret_cnt <= ret_next;
					if (issue) begin
						issue_cnt <= issue_cnt + 1'b1;
						if (issue_cnt + 1'b1 == edges) begin
							state <= CU_WAIT;
						end
					end
				end
				CU_WAIT: begin
					ret_cnt <= ret_next;
					if (ret_next == edges) begin
						vertex_count <= vertex_count + 1'b1;
						state        <= CU_IDLE;
					end
				end
				default: state <= CU_IDLE;
			endcase
		end
	end

	// job fields and edge address walk
	always_ff @(posedge clock) begin
		if (state == CU_IDLE && job.valid) begin
			edges     <= job.edge_count;
			next_addr <= job.edge_base;
		end else if (issue) begin
			next_addr <= next_addr + 1'b1;
		end
	end

endmodule

//--- hdl/read_cmd_arbiter.sv
`timescale 1ns/100ps

module read_cmd_arbiter import graph_ctrl_pkg::*; (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled,
	input  read_cmd_t         cu_cmd [NUM_CU],
	output logic [NUM_CU-1:0] cmd_buffer_alfull,
	input  logic              read_buffer_alfull,
	output read_cmd_t         read_cmd
);

	read_cmd_t             head [NUM_CU];
	buffer_status_t        status [NUM_CU];
	logic [NUM_CU-1:0]     nonempty;
	logic [NUM_CU-1:0]     pop;
	logic [CU_ID_BITS-1:0] last;
	logic [CU_ID_BITS-1:0] pick;
	logic                  allow;
	logic                  cmd_valid_q;
	read_cmd_t             cmd_q;

	//////////////////////////////////////////////////
	// per unit command buffers
	//////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < NUM_CU; g++) begin : gen_cmd_buffer
			sync_fifo #(
				.WIDTH($bits(read_cmd_t)),
				.DEPTH(CMD_BUFFER_DEPTH)
			) u_cmd_buffer (
				.clock   (clock),
				.rstn    (rstn),
				.push    (cu_cmd[g].valid),
				.data_in (cu_cmd[g]),
				.pop     (pop[g]),
				.data_out(head[g]),
				.status  (status[g])
			);

			assign nonempty[g]          = !status[g].empty;
			assign cmd_buffer_alfull[g] = status[g].alfull;
			assign pop[g]               = allow && (pick == CU_ID_BITS'(g));
		end
	endgenerate

	//////////////////////////////////////////////////
	// round-robin merge
	//////////////////////////////////////////////////

	assign allow = enabled && !read_buffer_alfull && (|nonempty);
	assign pick  = rr_next(nonempty, last);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last        <= '0;
			cmd_valid_q <= 1'b0;
		end else begin
			cmd_valid_q <= allow;
			if (allow) begin
				last <= pick;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (allow) begin
			cmd_q <= head[pick];
		end
	end

	always_comb begin
		read_cmd       = cmd_q;
		read_cmd.valid = cmd_valid_q;
	end

endmodule

//--- hdl/graph_algorithm_control.sv
`timescale 1ns/100ps

module graph_algorithm_control import graph_ctrl_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled_in,
	input  vertex_job_t           vertex_job,
	output logic                  vertex_job_request,
	output read_cmd_t             read_cmd,
	input  logic                  read_buffer_alfull,
	input  read_data_t            read_data,
	output logic [COUNT_BITS-1:0] vertex_done_count,
	output logic [COUNT_BITS-1:0] edge_done_count
);

	logic                  enabled;
	vertex_job_t           job_head;
	buffer_status_t        job_status;
	logic                  job_pop;
	vertex_job_t           cu_job [NUM_CU];
	logic [NUM_CU-1:0]     cu_request;
	read_cmd_t             cu_cmd [NUM_CU];
	logic [NUM_CU-1:0]     cmd_alfull;
	read_data_t            read_data_q;
	read_data_t            data_route_q;
	logic [NUM_CU-1:0]     cu_data_valid;
	read_data_t            cu_data [NUM_CU];
	logic [COUNT_BITS-1:0] cu_vertex_count [NUM_CU];
	logic [COUNT_BITS-1:0] cu_edge_count [NUM_CU];
	logic [COUNT_BITS-1:0] vertex_sum;
	logic [COUNT_BITS-1:0] edge_sum;

	//////////////////////////////////////////////////
	// enable and input registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			read_data_q <= '0;
		end else begin
			enabled     <= enabled_in;
			read_data_q <= read_data;
		end
	end

	//////////////////////////////////////////////////
	// job buffer and dispatch
	//////////////////////////////////////////////////

	assign vertex_job_request = enabled && !job_status.alfull;

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(JOB_BUFFER_DEPTH)
	) u_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_job.valid),
		.data_in (vertex_job),
		.pop     (job_pop),
		.data_out(job_head),
		.status  (job_status)
	);

	job_dispatch u_job_dispatch (
		.clock     (clock),
		.rstn      (rstn),
		.enabled   (enabled),
		.job_in    (job_head),
		.job_status(job_status),
		.job_pop   (job_pop),
		.cu_request(cu_request),
		.cu_job    (cu_job)
	);

	//////////////////////////////////////////////////
	// read data routing by cu_id
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_data_valid <= '0;
		end else begin
			for (int i = 0; i < NUM_CU; i++) begin
				cu_data_valid[i] <= enabled && read_data_q.valid &&
					(read_data_q.cu_id == CU_ID_BITS'(i));
			end
		end
	end

	always_ff @(posedge clock) begin
		data_route_q <= read_data_q;
	end

	//////////////////////////////////////////////////
	// compute units
	//////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < NUM_CU; g++) begin : gen_cu
			always_comb begin
				cu_data[g]       = data_route_q;
				cu_data[g].valid = cu_data_valid[g];
			end

			vertex_cu u_vertex_cu (
				.clock            (clock),
				.rstn             (rstn),
				.cu_id            (CU_ID_BITS'(g)),
				.job              (cu_job[g]),
				.job_request      (cu_request[g]),
				.cmd_buffer_alfull(cmd_alfull[g]),
				.cmd              (cu_cmd[g]),
				.data_in          (cu_data[g]),
				.vertex_count     (cu_vertex_count[g]),
				.edge_count       (cu_edge_count[g])
			);
		end
	endgenerate

	read_cmd_arbiter u_read_cmd_arbiter (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.cu_cmd            (cu_cmd),
		.cmd_buffer_alfull (cmd_alfull),
		.read_buffer_alfull(read_buffer_alfull),
		.read_cmd          (read_cmd)
	);

	//////////////////////////////////////////////////
	// done counts
	//////////////////////////////////////////////////

	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			vertex_sum = vertex_sum + cu_vertex_count[i];
			edge_sum   = edge_sum + cu_edge_count[i];
		end
	end

	// counts hold while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else if (enabled) begin
			vertex_done_count <= vertex_sum;
			edge_done_count   <= edge_sum;
		end
	end

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// reset held for 4 cycles, released on a falling edge
	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

//--- sim/graph_ctrl_asserts.sv
`timescale 1ns/100ps

module graph_ctrl_asserts import graph_ctrl_pkg::*; (
	input logic                  clock,
	input logic                  rstn,
	input logic                  enabled_in,
	input logic                  vertex_job_request,
	input logic                  read_buffer_alfull,
	input read_cmd_t             read_cmd,
	input logic [COUNT_BITS-1:0] vertex_done_count,
	input logic [COUNT_BITS-1:0] edge_done_count
);

	int assert_fails = 0;

	// quiet during reset and in the first cycle after it
	reset_quiet: assert property (@(posedge clock)
		(!rstn || $rose(rstn)) |->
			(!read_cmd.valid && !vertex_job_request &&
			vertex_done_count == '0 && edge_done_count == '0))
		else begin
			assert_fails++;
			$error("outputs active during reset or right after it");
		end

	alfull_stops_cmd: assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_alfull |=> !read_cmd.valid)
		else begin
			assert_fails++;
			$error("read command issued right after read_buffer_alfull");
		end

	// enable is registered, so the hold starts two cycles after the fall
	disable_holds: assert property (@(posedge clock) disable iff (!rstn)
		(!enabled_in && $past(!enabled_in) && $past(!enabled_in, 2)) |->
			(!read_cmd.valid && $stable(vertex_done_count) && $stable(edge_done_count)))
		else begin
			assert_fails++;
			$error("activity or count change while disabled");
		end

	counts_rise: assert property (@(posedge clock) disable iff (!rstn)
		(vertex_done_count >= $past(vertex_done_count)) &&
		(edge_done_count >= $past(edge_done_count)))
		else begin
			assert_fails++;
			$error("a done count decreased");
		end

endmodule

//--- sim/tb_graph_algorithm_control.sv
`timescale 1ns/100ps

module tb_graph_algorithm_control import graph_ctrl_pkg::*; ();

	localparam int NUM_JOBS      = 16;
	localparam int FIRST_JOBS    = 10;
	localparam int ZERO_JOB      = 3;
	localparam int REQ_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 1000;
	localparam int RESET_TIMEOUT = 50;
	localparam int JOB_BASE      = 32'h1000;
	localparam int JOB_STRIDE    = 16;

	logic                  clock;
	logic                  rstn;
	logic                  enabled_in;
	vertex_job_t           vertex_job;
	logic                  vertex_job_request;
	read_cmd_t             read_cmd;
	logic                  read_buffer_alfull;
	read_data_t            read_data;
	logic [COUNT_BITS-1:0] vertex_done_count;
	logic [COUNT_BITS-1:0] edge_done_count;

	int seed = 43;
	int cycle = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int jobs_pushed = 0;
	int edge_total = 0;
	int bp_left = 0;
	int bp_len;
	int err_mark;
	int waited;
	bit hold_resp = 1'b0;
	int job_edges [NUM_JOBS];
	int exp_hits [logic [ADDR_BITS-1:0]];
	logic [ADDR_BITS-1:0]  cmd_addrs [$];
	logic [CU_ID_BITS-1:0] cmd_cus [$];
	logic [CU_ID_BITS-1:0] resp_cu [$];
	logic [DATA_BITS-1:0]  resp_data [$];
	int                    resp_due [$];

	clock_gen u_clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	graph_algorithm_control DUT (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.vertex_job        (vertex_job),
		.vertex_job_request(vertex_job_request),
		.read_cmd          (read_cmd),
		.read_buffer_alfull(read_buffer_alfull),
		.read_data         (read_data),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count)
	);

	bind graph_algorithm_control graph_ctrl_asserts u_asserts (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.vertex_job_request(vertex_job_request),
		.read_buffer_alfull(read_buffer_alfull),
		.read_cmd          (read_cmd),
		.vertex_done_count (vertex_done_count),
		.edge_done_count   (edge_done_count)
	);

	//////////////////////////////////////////////////
	// memory responder
	//////////////////////////////////////////////////

	// in-order replies, 0 to 5 cycles after each command
	always @(negedge clock) begin : responder
		int due;
		cycle++;
		if (read_cmd.valid) begin
			cmd_addrs.push_back(read_cmd.addr);
			cmd_cus.push_back(read_cmd.cu_id);
			due = cycle + ({$random(seed)} % 6);
			if (resp_due.size() > 0 && due < resp_due[$]) begin
				due = resp_due[$];
			end
			resp_due.push_back(due);
			resp_cu.push_back(read_cmd.cu_id);
			resp_data.push_back(read_cmd.addr);
		end
		read_data = '0;
		if (!hold_resp && resp_due.size() > 0 && resp_due[0] <= cycle) begin
			read_data.valid = 1'b1;
			read_data.cu_id = resp_cu.pop_front();
			read_data.data  = resp_data.pop_front();
			void'(resp_due.pop_front());
		end
		read_buffer_alfull = (bp_left > 0);
		if (bp_left > 0) begin
			bp_left--;
		end
	end

	function automatic int total_errors();
		return errors + DUT.u_asserts.assert_fails;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic push_job(input int idx);
		logic [ADDR_BITS-1:0] base;
		int                   wait_req;
		base     = ADDR_BITS'(JOB_BASE + idx * JOB_STRIDE);
		wait_req = 0;
		while (!vertex_job_request && wait_req < REQ_TIMEOUT) begin
			@(negedge clock);
			wait_req++;
		end
		if (!vertex_job_request) begin
			$display("error: vertex_job_request stayed low, job %0d was not pushed", idx);
			errors++;
		end else begin
			vertex_job.valid      = 1'b1;
			vertex_job.vertex_id  = VERTEX_ID_BITS'(idx);
			vertex_job.edge_count = EDGE_COUNT_BITS'(job_edges[idx]);
			vertex_job.edge_base  = base;
			@(negedge clock);
			vertex_job = '0;
			jobs_pushed++;
			edge_total += job_edges[idx];
			for (int k = 0; k < job_edges[idx]; k++) begin
				exp_hits[base + ADDR_BITS'(k)] = 0;
			end
		end
	endtask

	task automatic wait_drain(input string name);
		int wait_done;
		wait_done = 0;
		while (int'(vertex_done_count) != jobs_pushed && wait_done < DRAIN_TIMEOUT) begin
			@(negedge clock);
			wait_done++;
		end
		if (int'(vertex_done_count) != jobs_pushed) begin
			$display("error in %s: jobs did not complete within %0d cycles", name, DRAIN_TIMEOUT);
			errors++;
		end
	endtask

	task automatic check_totals(input string name);
		if (int'(vertex_done_count) != jobs_pushed) begin
			$display("mismatch %s vertex_done_count: expected %0d, actual %0d",
				name, jobs_pushed, vertex_done_count);
			errors++;
		end
		if (int'(edge_done_count) != edge_total) begin
			$display("mismatch %s edge_done_count: expected %0d, actual %0d",
				name, edge_total, edge_done_count);
			errors++;
		end
	endtask

	task automatic check_commands(input string name);
		int extra;
		int missing;
		int repeated;
		int split;
		int job;
		int job_cu [int];
		extra    = 0;
		missing  = 0;
		repeated = 0;
		split    = 0;
		if (cmd_addrs.size() != edge_total) begin
			$display("mismatch %s command total: expected %0d, actual %0d",
				name, edge_total, cmd_addrs.size());
			errors++;
		end
		foreach (cmd_addrs[i]) begin
			if (exp_hits.exists(cmd_addrs[i])) begin
				exp_hits[cmd_addrs[i]]++;
				// one unit walks the whole range of a job
				job = (int'(cmd_addrs[i]) - JOB_BASE) / JOB_STRIDE;
				if (job_cu.exists(job) && job_cu[job] != int'(cmd_cus[i])) begin
					split++;
				end
				job_cu[job] = int'(cmd_cus[i]);
			end else begin
				extra++;
			end
		end
		foreach (exp_hits[a]) begin
			if (exp_hits[a] == 0) begin
				missing++;
			end else if (exp_hits[a] > 1) begin
				repeated++;
			end
		end
		if (extra + missing + repeated + split != 0) begin
			$display("error in %s: %0d stray, %0d unread, %0d repeated, %0d split addresses",
				name, extra, missing, repeated, split);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int mark);
		tests_run++;
		if (total_errors() > mark) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		// enable held high through reset
		enabled_in         = 1'b1;
		vertex_job         = '0;
		read_buffer_alfull = 1'b0;
		read_data          = '0;
		// all job sizes and the stall length drawn before the responder starts
		for (int i = 0; i < NUM_JOBS; i++) begin
			job_edges[i] = {$random(seed)} % 7;
		end
		job_edges[ZERO_JOB] = 0;
		bp_len = 8 + ({$random(seed)} % 16);

		err_mark = total_errors();
		waited   = 0;
		while (!rstn && waited < RESET_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (!rstn) begin
			$display("error: reset was never released");
			errors++;
		end
		wait_cycles(2);
		end_test("reset", err_mark);

		// back-pressure stretch in the middle of the first batch
		err_mark = total_errors();
		for (int i = 0; i < FIRST_JOBS; i++) begin
			if (i == FIRST_JOBS / 2) begin
				bp_left = bp_len;
			end
			push_job(i);
		end
		wait_drain("backpressure");
		check_totals("backpressure");
		end_test("backpressure", err_mark);

		// disable while the second batch is in flight
		err_mark = total_errors();
		for (int i = FIRST_JOBS; i < NUM_JOBS; i++) begin
			push_job(i);
		end
		// the last reply before the fall reaches its unit while disabled
		waited = 0;
		@(posedge clock);
		while (!read_data.valid && waited < REQ_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (!read_data.valid) begin
			$display("error: no read data returned before the disable");
			errors++;
		end
		hold_resp = 1'b1;
		@(negedge clock);
		enabled_in = 1'b0;
		wait_cycles(12);
		enabled_in = 1'b1;
		wait_cycles(3);
		hold_resp = 1'b0;
		wait_drain("disable");
		check_totals("disable");
		end_test("disable", err_mark);

		err_mark = total_errors();
		wait_cycles(10);
		check_commands("commands");
		end_test("commands", err_mark);

		$display("tests run: %0d, failed: %0d, errors: %0d",
			tests_run, tests_failed, total_errors());
		if (total_errors() == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- compile.f
hdl/graph_ctrl_pkg.sv
hdl/sync_fifo.sv
hdl/job_dispatch.sv
hdl/vertex_cu.sv
hdl/read_cmd_arbiter.sv
hdl/graph_algorithm_control.sv
sim/clock_gen.sv
sim/graph_ctrl_asserts.sv
sim/tb_graph_algorithm_control.sv

//--- Makefile
# Verilator flow for the graph algorithm control block

VERILATOR ?= verilator
TOP       ?= tb_graph_algorithm_control
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
